// File: lsu_pkg.sv
/* Data TCM load/store unit shared definitions
   Widths, two-bank geometry and access-size codes */
`default_nettype none

package lsu_pkg;

	// Data and address width of the core
	localparam int XLEN = 64;

	// Word index width of one bank, 1024 doublewords each
	localparam int DTCM_AW = 10;
	localparam int DTCM_WORDS = 1 << DTCM_AW;

	// Byte lane bits inside one doubleword
	// Bit LANE_W of the address picks the bank
	localparam int LANE_W = 3;
	localparam int BANK_LANES = 1 << LANE_W;

	// Destination register index, five bits plus a rename bit
	localparam int RD_W = 6;

	typedef logic [XLEN-1:0] xlen_t;
	typedef logic [DTCM_AW-1:0] bank_addr_t;
	typedef logic [BANK_LANES-1:0] byte_mask_t;
	typedef logic [1:0] mem_size_t;
	typedef logic [RD_W-1:0] rd_idx_t;

	// Access size codes, log2 of the byte count
	localparam mem_size_t SIZE_B = 2'd0;
	localparam mem_size_t SIZE_H = 2'd1;
	localparam mem_size_t SIZE_W = 2'd2;
	localparam mem_size_t SIZE_D = 2'd3;

endpackage

`default_nettype wire

// File: bank_if.sv
/* Request and read data of one doubleword bank */
`default_nettype none

interface bank_if;

	// Word index inside the bank
	lsu_pkg::bank_addr_t addr;
	// Store data, already lane aligned
	lsu_pkg::xlen_t wdata;
	logic wen;
	// One enable per byte lane
	lsu_pkg::byte_mask_t wmask;
	// Registered read word, valid one edge after addr
	lsu_pkg::xlen_t rdata;

	// Access stage side
	modport access (
		output addr,
		output wdata,
		output wen,
		output wmask
	);

	// Memory side
	modport bank (
		input addr,
		input wdata,
		input wen,
		input wmask,
		output rdata
	);

	// Load alignment side
	modport reader (
		input rdata
	);

endinterface

`default_nettype wire

// File: lsu_pipe_if.sv
/* Descriptor of the access taken on the previous edge
   Passed from the access stage to the load alignment stage */
`default_nettype none

interface lsu_pipe_if;

	// An access was accepted on the last edge
	logic valid;
	// Load when set, store otherwise
	logic is_load;
	lsu_pkg::mem_size_t size;
	logic is_unsigned;
	lsu_pkg::rd_idx_t rd;
	// Bank select bit and byte lane of the first byte
	logic [lsu_pkg::LANE_W:0] offset;

	modport src (
		output valid,
		output is_load,
		output size,
		output is_unsigned,
		output rd,
		output offset
	);

	modport dst (
		input valid,
		input is_load,
		input size,
		input is_unsigned,
		input rd,
		input offset
	);

endinterface

`default_nettype wire

// File: dtcm_bank.sv
/* Single-port 64-bit data TCM bank
   Byte-lane write enables, registered read */
`default_nettype none

module dtcm_bank (
	input wire logic CLK,
	bank_if.bank port
);

	// Storage, contents are undefined until written
	lsu_pkg::xlen_t mem [lsu_pkg::DTCM_WORDS];

	// Lane writes
	always_ff @(posedge CLK) begin
		if (port.wen) begin
			for (int lane = 0; lane < lsu_pkg::BANK_LANES; lane++) begin
				// Only lanes covered by the store
				if (port.wmask[lane]) begin
					mem[port.addr][lane*8 +: 8] <= port.wdata[lane*8 +: 8];
				end
			end
		end
	end

	// Read port runs every cycle
	// Returns the old word when a store hits the same index,
	// which the alignment stage ignores for stores anyway
	always_ff @(posedge CLK) begin
		port.rdata <= mem[port.addr];
	end

endmodule

`default_nettype wire

// File: lsu_access.sv
/* Access stage of the data TCM unit
   Load over store arbitration, bank split, store lane masks and data */
`default_nettype none

module lsu_access (
	input wire logic CLK,
	input wire logic rst_n,

	input wire logic lu_valid,
	input wire lsu_pkg::mem_size_t lu_size,
	input wire logic lu_unsigned,
	input wire lsu_pkg::rd_idx_t lu_rd,
	input wire lsu_pkg::xlen_t lu_addr,
	output logic lu_ready,

	input wire logic su_valid,
	input wire lsu_pkg::mem_size_t su_size,
	input wire lsu_pkg::xlen_t su_addr,
	input wire lsu_pkg::xlen_t su_data,
	output logic su_ready,

	bank_if.access even,
	bank_if.access odd,
	lsu_pipe_if.src pipe
);

	logic store_sel;
	logic take;
	lsu_pkg::xlen_t addr;
	logic bank_hi;
	logic [lsu_pkg::LANE_W-1:0] lane;
	lsu_pkg::bank_addr_t word_idx;
	logic [2*lsu_pkg::BANK_LANES-1:0] mask_base;
	logic [2*lsu_pkg::BANK_LANES-1:0] mask_span;
	logic [2*lsu_pkg::XLEN-1:0] data_span;

	// Memory never stalls, loads always go
	assign lu_ready = 1'b1;
	// Store waits while a load is offered
	assign su_ready = ~lu_valid;

	assign store_sel = su_valid & ~lu_valid;
	assign take = lu_valid | su_valid;

	// Address of the winning request
	assign addr = lu_valid ? lu_addr : su_addr;
	assign bank_hi = addr[lsu_pkg::LANE_W];
	assign lane = addr[lsu_pkg::LANE_W-1:0];
	assign word_idx = addr[lsu_pkg::LANE_W+1 +: lsu_pkg::DTCM_AW];

	// First byte in odd bank pushes the even bank to the next row
	// Wraps over the bank depth
	assign even.addr = bank_hi ? word_idx + 1'b1 : word_idx;
	assign odd.addr = word_idx;

	// Byte enables of the store before the lane shift
	always_comb begin
		case (su_size)
			lsu_pkg::SIZE_B: mask_base = 16'h0001;
			lsu_pkg::SIZE_H: mask_base = 16'h0003;
			lsu_pkg::SIZE_W: mask_base = 16'h000f;
			default: mask_base = 16'h00ff;
		endcase
	end

	// Spread over two doublewords, low half is the first bank
	assign mask_span = mask_base << lane;
	assign data_span = {{lsu_pkg::XLEN{1'b0}}, su_data} << {lane, 3'b000};

	// Swap halves when the first byte sits in the odd bank
	assign even.wmask = bank_hi ? mask_span[15:8] : mask_span[7:0];
	assign odd.wmask = bank_hi ? mask_span[7:0] : mask_span[15:8];
	assign even.wdata = bank_hi ? data_span[127:64] : data_span[63:0];
	assign odd.wdata = bank_hi ? data_span[63:0] : data_span[127:64];

	// Both banks write for any store, masks pick the lanes
	assign even.wen = store_sel;
	assign odd.wen = store_sel;

	// Descriptor for the alignment stage
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			pipe.valid <= 1'b0;
			pipe.is_load <= 1'b0;
			pipe.size <= lsu_pkg::SIZE_B;
			pipe.is_unsigned <= 1'b0;
			pipe.rd <= '0;
			pipe.offset <= '0;
		end else begin
			pipe.valid <= take;
			pipe.is_load <= lu_valid;
			pipe.size <= lu_valid ? lu_size : su_size;
			// Stores carry no extension or destination
			pipe.is_unsigned <= lu_valid & lu_unsigned;
			pipe.rd <= lu_valid ? lu_rd : '0;
			pipe.offset <= addr[lsu_pkg::LANE_W:0];
		end
	end

endmodule

`default_nettype wire

// File: lsu_load_align.sv
/* Load alignment stage of the data TCM unit
   Merges both bank words, extracts and extends the load, registers writeback */
`default_nettype none

module lsu_load_align (
	input wire logic CLK,
	input wire logic rst_n,

	bank_if.reader even,
	bank_if.reader odd,
	lsu_pipe_if.dst pipe,

	output logic wb_valid,
	output lsu_pkg::xlen_t wb_res,
	output lsu_pkg::rd_idx_t wb_rd
);

	logic [2*lsu_pkg::XLEN-1:0] window;
	logic [2*lsu_pkg::XLEN-1:0] shifted;
	lsu_pkg::xlen_t raw;
	lsu_pkg::xlen_t ext;
	logic is_rd;

	// First bank of the access goes to the low half
	assign window = pipe.offset[lsu_pkg::LANE_W] ? {even.rdata, odd.rdata}
		: {odd.rdata, even.rdata};

	// Addressed byte down to lane 0
	assign shifted = window >> {pipe.offset[lsu_pkg::LANE_W-1:0], 3'b000};
	assign raw = shifted[lsu_pkg::XLEN-1:0];

	// Sign or zero fill above the loaded size
	always_comb begin
		case (pipe.size)
			lsu_pkg::SIZE_B: begin
				ext = pipe.is_unsigned ? {56'b0, raw[7:0]}
					: {{56{raw[7]}}, raw[7:0]};
			end
			lsu_pkg::SIZE_H: begin
				ext = pipe.is_unsigned ? {48'b0, raw[15:0]}
					: {{48{raw[15]}}, raw[15:0]};
			end
			lsu_pkg::SIZE_W: begin
				ext = pipe.is_unsigned ? {32'b0, raw[31:0]}
					: {{32{raw[31]}}, raw[31:0]};
			end
			default: ext = raw;
		endcase
	end

	// Only a live load returns data
	assign is_rd = pipe.valid & pipe.is_load;

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			wb_valid <= 1'b0;
			wb_res <= '0;
			wb_rd <= '0;
		end else begin
			// Stores pulse too, with zero result and rd
			wb_valid <= pipe.valid;
			wb_res <= is_rd ? ext : '0;
			wb_rd <= is_rd ? pipe.rd : '0;
		end
	end

endmodule

`default_nettype wire

// File: lsu_top.sv
/* Data-side TCM load/store unit top
   Access stage, even and odd doubleword banks, load alignment */
`default_nettype none

module lsu_top (
	input wire logic CLK,
	input wire logic rst_n,

	// Load request
	input wire logic lu_valid,
	input wire lsu_pkg::mem_size_t lu_size,
	input wire logic lu_unsigned,
	input wire lsu_pkg::rd_idx_t lu_rd,
	input wire lsu_pkg::xlen_t lu_addr,
	output logic lu_ready,

	// Store request
	input wire logic su_valid,
	input wire lsu_pkg::mem_size_t su_size,
	input wire lsu_pkg::xlen_t su_addr,
	input wire lsu_pkg::xlen_t su_data,
	output logic su_ready,

	// Writeback, two cycles after acceptance
	output logic wb_valid,
	output lsu_pkg::xlen_t wb_res,
	output lsu_pkg::rd_idx_t wb_rd
);

	// Doublewords with address bit 3 clear
	bank_if even_bus ();
	// Doublewords with address bit 3 set
	bank_if odd_bus ();
	lsu_pipe_if pipe_bus ();

	lsu_access u_access (
		.CLK(CLK),
		.rst_n(rst_n),
		.lu_valid(lu_valid),
		.lu_size(lu_size),
		.lu_unsigned(lu_unsigned),
		.lu_rd(lu_rd),
		.lu_addr(lu_addr),
		.lu_ready(lu_ready),
		.su_valid(su_valid),
		.su_size(su_size),
		.su_addr(su_addr),
		.su_data(su_data),
		.su_ready(su_ready),
		.even(even_bus.access),
		.odd(odd_bus.access),
		.pipe(pipe_bus.src)
	);

	dtcm_bank bank_even (
		.CLK(CLK),
		.port(even_bus.bank)
	);

	dtcm_bank bank_odd (
		.CLK(CLK),
		.port(odd_bus.bank)
	);

	lsu_load_align u_load_align (
		.CLK(CLK),
		.rst_n(rst_n),
		.even(even_bus.reader),
		.odd(odd_bus.reader),
		.pipe(pipe_bus.dst),
		.wb_valid(wb_valid),
		.wb_res(wb_res),
		.wb_rd(wb_rd)
	);

endmodule

`default_nettype wire

// File: lsu_asserts.sv
/* Handshake and pipeline timing checks for the data TCM unit */
`default_nettype none

module lsu_asserts (
	input wire logic CLK,
	input wire logic rst_n,
	input wire logic lu_valid,
	input wire logic lu_ready,
	input wire logic su_valid,
	input wire logic su_ready,
	input wire logic wb_valid
);
	timeunit 1ns;
	timeprecision 1ps;

	logic take;

	// A load or a store goes into the banks this edge
	assign take = (lu_valid && lu_ready) || (su_valid && su_ready);

	// Memory never stalls loads
	assert property (@(posedge CLK) disable iff (!rst_n) lu_ready)
		else $error("lu_ready low");

	// Store held while a load is offered
	assert property (@(posedge CLK) disable iff (!rst_n) lu_valid |-> !su_ready)
		else $error("su_ready high with a load offered");

	// Fixed two cycle latency
	assert property (@(posedge CLK) disable iff (!rst_n) take |-> ##2 wb_valid)
		else $error("accepted request gave no writeback two cycles later");

	// And no pulse without a request
	assert property (@(posedge CLK) disable iff (!rst_n) wb_valid |-> $past(take, 2))
		else $error("writeback without a request two cycles earlier");

	// Quiet through reset and on the first edge after it
	assert property (@(posedge CLK) !rst_n |=> !wb_valid)
		else $error("wb_valid high during or right after reset");

endmodule

bind lsu_top lsu_asserts u_asserts (
	.CLK(CLK),
	.rst_n(rst_n),
	.lu_valid(lu_valid),
	.lu_ready(lu_ready),
	.su_valid(su_valid),
	.su_ready(su_ready),
	.wb_valid(wb_valid)
);

`default_nettype wire

// File: tb_lsu_top.sv
/* Testbench for the data TCM load/store unit
   Directed table, then LFSR traffic checked against a byte model */
`default_nettype none

module tb_lsu_top;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int RESET_CYCLES = 16;
	localparam int FILL_OPS = 64;
	localparam int RAND_OPS = 160;
	// Random traffic stays in 512 bytes that are filled first
	localparam logic [63:0] RAND_BASE = 64'h2000;
	localparam int K_LOAD = 0;
	localparam int K_STORE = 1;
	localparam int K_BOTH = 2;

	logic CLK = 1'b0;
	logic rst_n = 1'b0;
	logic lu_valid = 1'b0;
	lsu_pkg::mem_size_t lu_size = '0;
	logic lu_unsigned = 1'b0;
	lsu_pkg::rd_idx_t lu_rd = '0;
	lsu_pkg::xlen_t lu_addr = '0;
	logic su_valid = 1'b0;
	lsu_pkg::mem_size_t su_size = '0;
	lsu_pkg::xlen_t su_addr = '0;
	lsu_pkg::xlen_t su_data = '0;
	logic lu_ready;
	logic su_ready;
	logic wb_valid;
	lsu_pkg::xlen_t wb_res;
	lsu_pkg::rd_idx_t wb_rd;

	// Flat 16 KiB byte image
	logic [7:0] model_mem [16384];
	logic [31:0] lfsr = 32'h14ec;
	int cycle = 0;
	int limit;

	// Directed rows
	string t_name[$];
	int t_kind[$];
	lsu_pkg::mem_size_t t_size[$];
	logic t_uns[$];
	lsu_pkg::rd_idx_t t_rd[$];
	lsu_pkg::xlen_t t_addr[$];
	lsu_pkg::xlen_t t_data[$];
	lsu_pkg::xlen_t t_exp[$];

	// Writebacks still owed by the DUT, oldest first
	string q_name[$];
	lsu_pkg::xlen_t q_res[$];
	lsu_pkg::rd_idx_t q_rd[$];
	int q_cycle[$];

	lsu_top dut (.*);

	always #4 CLK = ~CLK;

	// Fibonacci LFSR, taps 32 22 2 1, one step per bit
	function automatic lsu_pkg::xlen_t rand_bits(input int n);
		lsu_pkg::xlen_t val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			val = {val[62:0], lfsr[0]};
		end
		return val;
	endfunction

	task automatic check_value(input string name, input lsu_pkg::xlen_t exp,
		input lsu_pkg::xlen_t act);
		if (act !== exp) begin
			$display("MISMATCH %s expected %h actual %h", name, exp, act);
			$display("Done: errors found");
			$fatal(1, "value check failed");
		end
	endtask

	// Little-endian read, wraps at 16 KiB, then extended
	function automatic lsu_pkg::xlen_t model_read(input lsu_pkg::xlen_t addr,
		input lsu_pkg::mem_size_t size, input logic uns);
		int nbits;
		lsu_pkg::xlen_t val;
		logic [13:0] idx;
		nbits = 8 << size;
		val = '0;
		for (int i = 0; i < (1 << size); i++) begin
			idx = addr[13:0] + 14'(i);
			val[i*8 +: 8] = model_mem[idx];
		end
		if (!uns && nbits < 64 && val[nbits-1]) begin
			val = val | (~64'd0 << nbits);
		end
		return val;
	endfunction

	function automatic void model_write(input lsu_pkg::xlen_t addr,
		input lsu_pkg::mem_size_t size, input lsu_pkg::xlen_t data);
		logic [13:0] idx;
		for (int i = 0; i < (1 << size); i++) begin
			idx = addr[13:0] + 14'(i);
			model_mem[idx] = data[i*8 +: 8];
		end
	endfunction

	// Size given in bytes
	task automatic add_row(input string name, input int kind, input int nbytes,
		input int uns, input int rd, input lsu_pkg::xlen_t addr,
		input lsu_pkg::xlen_t data, input lsu_pkg::xlen_t exp);
		t_name.push_back(name);
		t_kind.push_back(kind);
		t_size.push_back(lsu_pkg::mem_size_t'($clog2(nbytes)));
		t_uns.push_back(uns != 0);
		t_rd.push_back(lsu_pkg::rd_idx_t'(rd));
		t_addr.push_back(addr);
		t_data.push_back(data);
		t_exp.push_back(exp);
	endtask

	// Mid-cycle look at the handshake, transfer happens on the next edge
	task automatic record(input string name, input lsu_pkg::xlen_t exp);
		// Loads are always taken
		check_value({name, " lu_ready"}, 64'd1, 64'(lu_ready));
		if (lu_valid) begin
			q_res.push_back(exp);
			q_rd.push_back(lu_rd);
		end else begin
			// Store goes when no load is offered
			check_value({name, " su_ready"}, 64'd1, 64'(su_ready));
			model_write(su_addr, su_size, su_data);
			q_res.push_back('0);
			q_rd.push_back('0);
		end
		q_name.push_back(name);
		q_cycle.push_back(cycle + 2);
	endtask

	// One request per cycle, driven just after the edge
	task automatic issue(input string name, input int kind, input lsu_pkg::mem_size_t size,
		input logic uns, input lsu_pkg::rd_idx_t rd, input lsu_pkg::xlen_t addr,
		input lsu_pkg::xlen_t data, input lsu_pkg::xlen_t exp);
		@(posedge CLK);
		#1;
		lu_valid = (kind != K_STORE);
		lu_size = size;
		lu_unsigned = uns;
		lu_rd = rd;
		lu_addr = addr;
		su_valid = (kind != K_LOAD);
		su_size = size;
		su_addr = addr;
		su_data = data;
		@(negedge CLK);
		if (kind == K_BOTH) begin
			check_value({name, " su_ready with load"}, 64'd0, 64'(su_ready));
		end
		record(name, exp);
		// Held store goes on the following cycle
		if (kind == K_BOTH) begin
			@(posedge CLK);
			#1;
			lu_valid = 1'b0;
			@(negedge CLK);
			record({name, " store"}, '0);
		end
	endtask

	// Writeback checker, in order, with exact latency
	always @(negedge CLK) begin
		if (wb_valid) begin
			if (q_res.size() == 0) begin
				$display("Writeback seen at cycle %0d with no request outstanding", cycle);
				$display("Done: errors found");
				$fatal(1, "unexpected writeback");
			end else begin
				check_value({q_name[0], " rd"}, 64'(q_rd[0]), 64'(wb_rd));
				check_value({q_name[0], " result"}, q_res[0], wb_res);
				check_value({q_name[0], " cycle"}, 64'(q_cycle[0]), 64'(cycle));
				void'(q_name.pop_front());
				void'(q_res.pop_front());
				void'(q_rd.pop_front());
				void'(q_cycle.pop_front());
			end
		end
	end

	always @(posedge CLK) begin
		cycle <= cycle + 1;
		if (cycle >= limit) begin
			$display("Run stopped at cycle %0d with %0d writebacks missing", cycle, q_res.size());
			$display("Done: errors found");
			$fatal(1, "timeout");
		end
	end

	initial begin
		lsu_pkg::xlen_t addr;
		lsu_pkg::mem_size_t size;
		logic uns;
		// name, kind, bytes, unsigned, rd, address, store data, load result
		add_row("st_d0", K_STORE, 8, 0, 0, 64'h00, 64'h8877_6655_4433_2211, 64'h0);
		add_row("st_d8", K_STORE, 8, 0, 0, 64'h08, 64'hf0e1_d2c3_b4a5_9687, 64'h0);
		add_row("ld_d0", K_LOAD, 8, 0, 1, 64'h00, 64'h0, 64'h8877_6655_4433_2211);
		add_row("ld_d8", K_LOAD, 8, 0, 2, 64'h08, 64'h0, 64'hf0e1_d2c3_b4a5_9687);
		add_row("st_b", K_STORE, 1, 0, 0, 64'h10, 64'hffff_ffff_ffff_ff80, 64'h0);
		add_row("st_w", K_STORE, 4, 0, 0, 64'h14, 64'h5555_5555_8000_0001, 64'h0);
		add_row("ld_b_s", K_LOAD, 1, 0, 3, 64'h10, 64'h0, 64'hffff_ffff_ffff_ff80);
		add_row("ld_b_u", K_LOAD, 1, 1, 4, 64'h10, 64'h0, 64'h0000_0000_0000_0080);
		add_row("ld_w_s", K_LOAD, 4, 0, 5, 64'h14, 64'h0, 64'hffff_ffff_8000_0001);
		add_row("ld_w_u", K_LOAD, 4, 1, 6, 64'h14, 64'h0, 64'h0000_0000_8000_0001);
		add_row("ld_h_s", K_LOAD, 2, 0, 7, 64'h16, 64'h0, 64'hffff_ffff_ffff_8000);
		// Crossing even to odd
		add_row("ld_h07", K_LOAD, 2, 0, 8, 64'h07, 64'h0, 64'hffff_ffff_ffff_8788);
		add_row("ld_d03", K_LOAD, 8, 0, 9, 64'h03, 64'h0, 64'ha596_8788_7766_5544);
		// Crossing odd to even
		add_row("st_d1b", K_STORE, 8, 0, 0, 64'h1b, 64'h0123_4567_89ab_cdef, 64'h0);
		add_row("ld_d1b", K_LOAD, 8, 0, 10, 64'h1b, 64'h0, 64'h0123_4567_89ab_cdef);
		add_row("ld_w1e", K_LOAD, 4, 0, 11, 64'h1e, 64'h0, 64'h0000_0000_2345_6789);
		add_row("st_h27", K_STORE, 2, 0, 0, 64'h27, 64'h0000_0000_0000_c1b2, 64'h0);
		add_row("ld_h27", K_LOAD, 2, 1, 12, 64'h27, 64'h0, 64'h0000_0000_0000_c1b2);
		// Top of the space wraps to byte 0
		add_row("st_wrap", K_STORE, 8, 0, 0, 64'h3ffc, 64'hdead_beef_cafe_f00d, 64'h0);
		add_row("ld_wrap", K_LOAD, 8, 0, 13, 64'h3ffc, 64'h0, 64'hdead_beef_cafe_f00d);
		add_row("ld_w0", K_LOAD, 4, 1, 14, 64'h00, 64'h0, 64'h0000_0000_dead_beef);
		// Load wins, store follows, next load sees it
		add_row("st_d40", K_STORE, 8, 0, 0, 64'h40, 64'h1111_2222_3333_4444, 64'h0);
		add_row("both_40", K_BOTH, 8, 0, 15, 64'h40, 64'h5555_6666_7777_8888,
			64'h1111_2222_3333_4444);
		add_row("ld_d40", K_LOAD, 8, 0, 16, 64'h40, 64'h0, 64'h5555_6666_7777_8888);
		limit = RESET_CYCLES + 4 * (t_name.size() + FILL_OPS + RAND_OPS) + 20;

		repeat (RESET_CYCLES) @(posedge CLK);
		#1;
		rst_n = 1'b1;

		for (int i = 0; i < t_name.size(); i++) begin
			issue(t_name[i], t_kind[i], t_size[i], t_uns[i], t_rd[i], t_addr[i], t_data[i],
				t_exp[i]);
		end
		// Doubleword fill of the random region
		for (int i = 0; i < FILL_OPS; i++) begin
			addr = RAND_BASE + 64'(i * 8);
			issue("fill", K_STORE, lsu_pkg::SIZE_D, 1'b0, '0, addr,
				{~addr[31:0], addr[31:0] ^ 32'h9e37_79b9}, '0);
		end
		// Mixed traffic back to back
		for (int i = 0; i < RAND_OPS; i++) begin
			size = lsu_pkg::mem_size_t'(rand_bits(2));
			uns = 1'(rand_bits(1));
			addr = RAND_BASE + rand_bits(8);
			if (rand_bits(1) != 0) begin
				issue($sformatf("rand_st_%0d", i), K_STORE, size, 1'b0, '0, addr,
					rand_bits(64), '0);
			end else begin
				issue($sformatf("rand_ld_%0d", i), K_LOAD, size, uns,
					lsu_pkg::rd_idx_t'(rand_bits(6)), addr, '0, model_read(addr, size, uns));
			end
		end
		@(posedge CLK);
		#1;
		lu_valid = 1'b0;
		su_valid = 1'b0;

		while (q_res.size() != 0) begin
			@(negedge CLK);
		end
		// A few idle cycles to catch a stray pulse
		repeat (4) @(posedge CLK);
		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
lsu_pkg.sv
bank_if.sv
lsu_pipe_if.sv
dtcm_bank.sv
lsu_access.sv
lsu_load_align.sv
lsu_top.sv
lsu_asserts.sv
tb_lsu_top.sv

// File: run.sh
#!/bin/sh
# Build and run the data TCM unit testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal -f sources.f --top-module tb_lsu_top -o sim_lsu &&
./obj_dir/sim_lsu || { echo "simulation failed"; exit 1; }
